/* sim/alu_input.txt */
00 7fffffffffffffff 0000000000000001 8000000000000000
02 0000000000000000 0000000000000001 ffffffffffffffff
01 000000007fffffff 0000000000000001 ffffffff80000000
03 0000000100000005 0000000000000007 fffffffffffffffe
04 ffffffffffffffff 0000000000000001 0000000000000001
05 ffffffffffffffff 0000000000000001 0000000000000000
06 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000
07 f0f0f0f0f0f0f0f0 0f0f00000f0f0000 fffff0f0fffff0f0
08 123456789abcdef0 ffffffffffffffff edcba9876543210f
09 0000000000000001 000000000000003f 8000000000000000
0a 00000000000000ff 0000000000000024 00000ff000000000
0b 0000000000000001 000000000000001f ffffffff80000000
0c 0000000012345678 0000000000000024 0000000023456780
0d 8000000000000000 000000000000003f 0000000000000001
0e f000000000000000 0000000000000020 00000000f0000000
0f ffffffff80000000 0000000000000004 0000000008000000
10 12345678f0000000 0000000000000021 0000000078000000
11 8000000000000000 000000000000003c fffffffffffffff8
12 ff00000000000000 0000000000000028 ffffffffffff0000
13 0000000080000000 000000000000001f ffffffffffffffff
14 00000000f0000010 0000000000000004 ffffffffff000001
1d 0000000100000001 0000000100000001 0000000200000001
1e 8000000000000000 0000000000000002 ffffffffffffffff
1f ffffffffffffffff ffffffffffffffff ffffffffffffffff
20 ffffffffffffffff ffffffffffffffff fffffffffffffffe
21 123456787fffffff 0000000000000002 fffffffffffffffe
19 ffffffffffffff9c 0000000000000007 fffffffffffffff2
15 ffffffffffffff9c 0000000000000007 fffffffffffffffe
1a ffffffffffffffff 0000000000000010 0fffffffffffffff
16 ffffffffffffffff 0000000000000000 ffffffffffffffff
19 0000000000000005 0000000000000000 ffffffffffffffff
19 8000000000000000 ffffffffffffffff 8000000000000000
1c aaaaaaaaffffff9c 12345678fffffff9 000000000000000e
18 0000000080000000 00000000ffffffff 0000000000000000
1b 00000000fffffffe 0000000000000002 000000007fffffff
17 0000000080000007 0000000000000000 ffffffff80000007

/* tb.f */
logic/alu_pkg.sv
logic/alu_int_ops.sv
logic/alu_mul_iter.sv
logic/alu_div_iter.sv
logic/alu_top.sv
sim/alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the ALU testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module alu_tb -o alu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/alu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

/* sim/alu_tb.sv */
`timescale 1ns/10ps

module alu_tb;

  localparam int max_vec = 64;

  logic              clk;
  logic              rst;
  alu_pkg::word_t    op_1;
  alu_pkg::word_t    op_2;
  alu_pkg::alu_sel_t alu_sel;
  logic              lsu_stall;
  logic              alu_stall;
  logic              alu_ok;
  alu_pkg::word_t    result;

  logic [7:0]     vec_op  [max_vec];
  alu_pkg::word_t vec_a   [max_vec];
  alu_pkg::word_t vec_b   [max_vec];
  alu_pkg::word_t vec_exp [max_vec];

  int          n_vec = 0;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  logic        loaded = 1'b0;
  logic [31:0] lfsr_state = 32'hecbdfd39;

  alu_top dut (
    .clk       (clk),
    .rst       (rst),
    .op_1      (op_1),
    .op_2      (op_2),
    .alu_sel   (alu_sel),
    .lsu_stall (lsu_stall),
    .alu_stall (alu_stall),
    .alu_ok    (alu_ok),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  task automatic report_mismatch(input string name, input alu_pkg::word_t exp,
                                 input alu_pkg::word_t got);
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic report_latency(input int exp, input int got);
    $display("mismatch at %0t: alu_ok latency expected %0d got %0d cycles", $time, exp, got);
    err_cnt++;
  endtask

  task automatic load_vectors();
    int             fd;
    int             n;
    logic [7:0]     op;
    alu_pkg::word_t a;
    alu_pkg::word_t b;
    alu_pkg::word_t e;
    fd = $fopen("sim/alu_input.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd) && n_vec < max_vec) begin
      n = $fscanf(fd, "%h %h %h %h\n", op, a, b, e);
      if (n != 4) begin
        break;
      end
      if (op > alu_pkg::sel_mulw) begin
        $display("vector line %0d names op %0d, which the ALU does not have", n_vec + 1, op);
        err_cnt++;
      end else begin
        vec_op[n_vec]  = op;
        vec_a[n_vec]   = a;
        vec_b[n_vec]   = b;
        vec_exp[n_vec] = e;
        n_vec++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_vector(input int idx);
    alu_sel   <= alu_pkg::alu_sel_t'(34'd1) << vec_op[idx];
    op_1      <= vec_a[idx];
    op_2      <= vec_b[idx];
    lsu_stall <= take_bit();
  endtask

  // combinational op, answer expected within the same cycle
  task automatic run_simple(input int idx);
    @(posedge clk);
    drive_vector(idx);
    @(negedge clk);
    if (result !== vec_exp[idx]) report_mismatch("result", vec_exp[idx], result);
    if (alu_ok !== 1'b0) report_mismatch("alu_ok", 64'd0, {63'd0, alu_ok});
    if (alu_stall !== 1'b0) report_mismatch("alu_stall", 64'd0, {63'd0, alu_stall});
  endtask

  // multiply or divide, held until taken with lsu_stall low
  task automatic run_iter(input int idx);
    int             latency;
    int             edges;
    logic           got_ok;
    logic           accepted;
    logic           holding;
    alu_pkg::word_t held;
    latency  = (vec_op[idx] >= alu_pkg::sel_mul) ? alu_pkg::mul_cycles + 1 :
                                                   alu_pkg::div_cycles + 2;
    edges    = -1;
    got_ok   = 1'b0;
    accepted = 1'b0;
    holding  = 1'b0;
    held     = '0;
    @(posedge clk);
    drive_vector(idx);
    @(negedge clk);
    if (alu_stall !== 1'b0) report_mismatch("alu_stall", 64'd0, {63'd0, alu_stall});
    while (!accepted && edges < latency + 100) begin
      @(posedge clk);
      lsu_stall <= take_bit();
      edges++;
      @(negedge clk);
      // edge 0 is the accepting edge
      if (edges == 0 && alu_stall !== 1'b1) begin
        report_mismatch("alu_stall", 64'd1, {63'd0, alu_stall});
      end
      if (holding) begin
        if (alu_ok !== 1'b1) report_mismatch("alu_ok", 64'd1, {63'd0, alu_ok});
        if (result !== held) report_mismatch("result", held, result);
      end
      if (alu_ok === 1'b1 && !got_ok) begin
        got_ok = 1'b1;
        if (edges != latency) report_latency(latency, edges);
      end
      if (alu_ok === 1'b1 && !lsu_stall) begin
        if (result !== vec_exp[idx]) report_mismatch("result", vec_exp[idx], result);
        accepted = 1'b1;
      end
      holding = (alu_ok === 1'b1) && lsu_stall;
      held    = result;
    end
    if (!accepted) begin
      $display("test %0d: alu_ok was never taken within %0d cycles", idx, latency + 100);
      err_cnt++;
    end
    // requester drops the select after the handover
    @(posedge clk);
    alu_sel   <= '0;
    lsu_stall <= take_bit();
    @(negedge clk);
    if (alu_stall !== 1'b0) report_mismatch("alu_stall", 64'd0, {63'd0, alu_stall});
    if (alu_ok !== 1'b0) report_mismatch("alu_ok", 64'd0, {63'd0, alu_ok});
  endtask

  initial begin : main
    int errs_before;
    rst       = 1'b1;
    op_1      = '0;
    op_2      = '0;
    alu_sel   = '0;
    lsu_stall = 1'b0;
    load_vectors();
    loaded = 1'b1;
    if (n_vec == 0) begin
      $display("no test vectors could be read from sim/alu_input.txt");
      err_cnt++;
    end else begin
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      if (alu_stall !== 1'b0) report_mismatch("alu_stall", 64'd0, {63'd0, alu_stall});
      if (alu_ok !== 1'b0) report_mismatch("alu_ok", 64'd0, {63'd0, alu_ok});
      for (int i = 0; i < n_vec; i++) begin
        errs_before = err_cnt;
        if (vec_op[i] <= alu_pkg::sel_sraw) begin
          run_simple(i);
        end else begin
          run_iter(i);
        end
        if (err_cnt == errs_before) begin
          pass_cnt++;
          $display("test %0d (op %0d): pass", i, vec_op[i]);
        end else begin
          fail_cnt++;
          $display("test %0d (op %0d): failed", i, vec_op[i]);
        end
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             n_vec, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog, 200 cycles per vector plus reset margin
  initial begin : watchdog
    wait (loaded);
    repeat ((n_vec + 1) * 200) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", (n_vec + 1) * 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* logic/alu_top.sv */
`timescale 1ns/10ps

module alu_top (
  input  logic              clk,
  input  logic              rst,
  input  alu_pkg::word_t    op_1,
  input  alu_pkg::word_t    op_2,
  input  alu_pkg::alu_sel_t alu_sel,
  input  logic              lsu_stall,
  output logic              alu_stall,
  output logic              alu_ok,
  output alu_pkg::word_t    result
);

  alu_pkg::unit_req_t mul_req;
  alu_pkg::unit_req_t div_req;
  logic               result_ready;
  logic               simple_hit;
  alu_pkg::word_t     simple_out;
  alu_pkg::word_t     mul_out;
  alu_pkg::word_t     div_out;
  logic               mul_stall;
  logic               mul_ok;
  logic               div_stall;
  logic               div_ok;

  // load/store stage takes the result when it is not stalled
  assign result_ready = ~lsu_stall;

  assign mul_req = '{start: |(alu_sel & alu_pkg::mul_mask), sel: alu_sel, a: op_1, b: op_2};
  assign div_req = '{start: |(alu_sel & alu_pkg::div_mask), sel: alu_sel, a: op_1, b: op_2};

  alu_int_ops u_int_ops (
    .a          (op_1),
    .b          (op_2),
    .sel        (alu_sel),
    .simple_out (simple_out)
  );

  alu_mul_iter u_mul (
    .clk          (clk),
    .rst          (rst),
    .req          (mul_req),
    .result_ready (result_ready),
    .stall        (mul_stall),
    .ok           (mul_ok),
    .out          (mul_out)
  );

  alu_div_iter u_div (
    .clk          (clk),
    .rst          (rst),
    .req          (div_req),
    .result_ready (result_ready),
    .stall        (div_stall),
    .ok           (div_ok),
    .out          (div_out)
  );

  assign alu_stall = mul_stall | div_stall;
  assign alu_ok    = mul_ok | div_ok;

  // idle units drive zero, so their outputs can share an or
  assign simple_hit = |(alu_sel & alu_pkg::simple_mask);
  assign result     = simple_hit ? simple_out : (mul_out | div_out);

  a_sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(alu_sel));

endmodule

/* logic/alu_div_iter.sv */
`timescale 1ns/10ps

module alu_div_iter (
  input  logic               clk,
  input  logic               rst,
  input  alu_pkg::unit_req_t req,
  input  logic               result_ready,
  output logic               stall,
  output logic               ok,
  output alu_pkg::word_t     out
);

  alu_pkg::unit_state_e                      state_q;
  logic [$clog2(alu_pkg::div_cycles+2)-1:0] cnt_q;
  alu_pkg::alu_sel_t                         sel_q;
  alu_pkg::word_t                            a_q;
  alu_pkg::word_t                            b_q;
  alu_pkg::word_t                            divisor_q;
  alu_pkg::word_t                            rem_q;
  alu_pkg::word_t                            quot_q;

  logic                   word_op;
  logic                   signed_op;
  alu_pkg::word_t         a_ext;
  alu_pkg::word_t         b_ext;
  logic                   a_neg;
  logic                   b_neg;
  logic                   div_zero;
  logic                   overflow;
  alu_pkg::word_t         min_val;
  logic [alu_pkg::xlen:0] shifted;
  logic [alu_pkg::xlen:0] diff;
  alu_pkg::word_t         quot_fix;
  alu_pkg::word_t         rem_fix;
  alu_pkg::word_t         result_sel;

  assign word_op   = sel_q[alu_pkg::sel_divw] | sel_q[alu_pkg::sel_divuw] |
                     sel_q[alu_pkg::sel_remw] | sel_q[alu_pkg::sel_remuw];
  assign signed_op = sel_q[alu_pkg::sel_div]  | sel_q[alu_pkg::sel_rem] |
                     sel_q[alu_pkg::sel_divw] | sel_q[alu_pkg::sel_remw];

  // word forms look at the low word only
  always_comb begin
    a_ext = a_q;
    b_ext = b_q;
    if (word_op) begin
      a_ext = signed_op ? alu_pkg::sext_word(a_q[31:0]) : {32'd0, a_q[31:0]};
      b_ext = signed_op ? alu_pkg::sext_word(b_q[31:0]) : {32'd0, b_q[31:0]};
    end
  end

  assign a_neg    = signed_op & a_ext[63];
  assign b_neg    = signed_op & b_ext[63];
  assign div_zero = (b_ext == '0);
  assign min_val  = word_op ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
  assign overflow = signed_op && (a_ext == min_val) && (&b_ext);

  // restoring step keeps the trial difference only when it did not borrow
  assign shifted = {rem_q, quot_q[63]};
  assign diff    = shifted - {1'b0, divisor_q};

  // quotient sign is the xor of both signs and the remainder follows the dividend
  always_comb begin
    if (div_zero) begin
      quot_fix = '1;
      rem_fix  = a_ext;
    end else if (overflow) begin
      quot_fix = a_ext;
      rem_fix  = '0;
    end else begin
      quot_fix = (a_neg ^ b_neg) ? -quot_q : quot_q;
      rem_fix  = a_neg ? -rem_q : rem_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= alu_pkg::st_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        alu_pkg::st_idle: begin
          if (req.start) begin
            state_q <= alu_pkg::st_busy;
            cnt_q   <= '0;
          end
        end
        alu_pkg::st_busy: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == alu_pkg::div_cycles + 1) begin
            state_q <= alu_pkg::st_done;
          end
        end
        alu_pkg::st_done: begin
          if (result_ready) begin
            state_q <= alu_pkg::st_idle;
          end
        end
        default: state_q <= alu_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == alu_pkg::st_idle && req.start) begin
      sel_q <= req.sel;
      a_q   <= req.a;
      b_q   <= req.b;
    end else if (state_q == alu_pkg::st_busy) begin
      if (cnt_q == '0) begin
        // operand conditioning
        divisor_q <= b_neg ? -b_ext : b_ext;
        quot_q    <= a_neg ? -a_ext : a_ext;
        rem_q     <= '0;
      end else if (cnt_q <= alu_pkg::div_cycles) begin
        rem_q  <= diff[alu_pkg::xlen] ? shifted[alu_pkg::xlen-1:0] : diff[alu_pkg::xlen-1:0];
        quot_q <= {quot_q[62:0], ~diff[alu_pkg::xlen]};
      end else begin
        quot_q <= quot_fix;
        rem_q  <= rem_fix;
      end
    end
  end

  always_comb begin
    case (1'b1)
      sel_q[alu_pkg::sel_rem],
      sel_q[alu_pkg::sel_remu]:   result_sel = rem_q;
      sel_q[alu_pkg::sel_remw],
      sel_q[alu_pkg::sel_remuw]:  result_sel = alu_pkg::sext_word(rem_q[31:0]);
      sel_q[alu_pkg::sel_div],
      sel_q[alu_pkg::sel_divu]:   result_sel = quot_q;
      sel_q[alu_pkg::sel_divw],
      sel_q[alu_pkg::sel_divuw]:  result_sel = alu_pkg::sext_word(quot_q[31:0]);
      default:                    result_sel = quot_q;
    endcase
  end

  assign stall = (state_q != alu_pkg::st_idle);
  assign ok    = (state_q == alu_pkg::st_done);
  assign out   = ok ? result_sel : '0;

  a_ok_stall: assert property (@(posedge clk) disable iff (rst)
    ok |-> (stall && $past(stall)));
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (ok && !result_ready) |=> (ok && $stable(out)));

endmodule

/* logic/alu_mul_iter.sv */
`timescale 1ns/10ps

module alu_mul_iter (
  input  logic               clk,
  input  logic               rst,
  input  alu_pkg::unit_req_t req,
  input  logic               result_ready,
  output logic               stall,
  output logic               ok,
  output alu_pkg::word_t     out
);

  alu_pkg::unit_state_e                      state_q;
  logic [$clog2(alu_pkg::mul_cycles+1)-1:0] cnt_q;
  alu_pkg::alu_sel_t                         sel_q;
  logic                                      neg_q;
  alu_pkg::word_t                            mcand_q;
  logic [2*alu_pkg::xlen-1:0]                prod_q;

  logic                       a_neg;
  logic                       b_neg;
  alu_pkg::word_t             a_mag;
  alu_pkg::word_t             b_mag;
  logic [alu_pkg::xlen:0]     partial;
  logic [2*alu_pkg::xlen-1:0] prod_step;
  alu_pkg::word_t             result_sel;

  // mulh takes both operands as signed and mulhsu only a
  assign a_neg = (req.sel[alu_pkg::sel_mulh] | req.sel[alu_pkg::sel_mulhsu]) & req.a[63];
  assign b_neg = req.sel[alu_pkg::sel_mulh] & req.b[63];
  assign a_mag = a_neg ? -req.a : req.a;
  assign b_mag = b_neg ? -req.b : req.b;

  // add multiplicand into the upper half and shift the whole product right
  assign partial   = {1'b0, prod_q[127:64]} + (prod_q[0] ? {1'b0, mcand_q} : '0);
  assign prod_step = {partial, prod_q[63:1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= alu_pkg::st_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        alu_pkg::st_idle: begin
          if (req.start) begin
            state_q <= alu_pkg::st_busy;
            cnt_q   <= '0;
          end
        end
        alu_pkg::st_busy: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == alu_pkg::mul_cycles) begin
            state_q <= alu_pkg::st_done;
          end
        end
        alu_pkg::st_done: begin
          if (result_ready) begin
            state_q <= alu_pkg::st_idle;
          end
        end
        default: state_q <= alu_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == alu_pkg::st_idle && req.start) begin
      sel_q   <= req.sel;
      neg_q   <= a_neg ^ b_neg;
      mcand_q <= a_mag;
      prod_q  <= {{alu_pkg::xlen{1'b0}}, b_mag};
    end else if (state_q == alu_pkg::st_busy) begin
      // extra cycle after the last step restores the sign
      if (cnt_q == alu_pkg::mul_cycles) begin
        if (neg_q) begin
          prod_q <= -prod_q;
        end
      end else begin
        prod_q <= prod_step;
      end
    end
  end

  always_comb begin
    case (1'b1)
      sel_q[alu_pkg::sel_mul]:    result_sel = prod_q[63:0];
      sel_q[alu_pkg::sel_mulh],
      sel_q[alu_pkg::sel_mulhsu],
      sel_q[alu_pkg::sel_mulhu]:  result_sel = prod_q[127:64];
      sel_q[alu_pkg::sel_mulw]:   result_sel = alu_pkg::sext_word(prod_q[31:0]);
      default:                    result_sel = prod_q[63:0];
    endcase
  end

  assign stall = (state_q != alu_pkg::st_idle);
  assign ok    = (state_q == alu_pkg::st_done);
  assign out   = ok ? result_sel : '0;

  a_ok_stall: assert property (@(posedge clk) disable iff (rst)
    ok |-> (stall && $past(stall)));
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (ok && !result_ready) |=> (ok && $stable(out)));

endmodule

/* logic/alu_int_ops.sv */
`timescale 1ns/10ps

module alu_int_ops (
  input  alu_pkg::word_t    a,
  input  alu_pkg::word_t    b,
  input  alu_pkg::alu_sel_t sel,
  output alu_pkg::word_t    simple_out
);

  logic            sub_mode;
  alu_pkg::word_t  b_in;
  alu_pkg::word_t  sum;
  alu_pkg::word_t  sum_w;
  alu_pkg::word_t  slt_res;
  alu_pkg::word_t  sltu_res;
  logic            shamt_hi;
  alu_pkg::shamt_t shamt;
  alu_pkg::word_t  srl_src;
  alu_pkg::word_t  sra_src;
  alu_pkg::word_t  sll_res;
  alu_pkg::word_t  srl_res;
  alu_pkg::word_t  sra_res;

  // one adder serves add, sub and both compares
  assign sub_mode = sel[alu_pkg::sel_sub] | sel[alu_pkg::sel_subw] |
                    sel[alu_pkg::sel_slt] | sel[alu_pkg::sel_sltu];
  assign b_in     = sub_mode ? (~b + 64'd1) : b;
  assign sum      = a + b_in;
  assign sum_w    = alu_pkg::sext_word(sum[31:0]);

  // mixed signs decide directly, equal signs look at the difference
  assign slt_res  = ((a[63] && !b[63]) || ((a[63] == b[63]) && sum[63])) ? 64'd1 : 64'd0;
  assign sltu_res = ((!a[63] && b[63]) || ((a[63] == b[63]) && sum[63])) ? 64'd1 : 64'd0;

  // bit 5 of the amount only counts for the 64-bit shifts
  assign shamt_hi = sel[alu_pkg::sel_sll] | sel[alu_pkg::sel_slli] |
                    sel[alu_pkg::sel_srl] | sel[alu_pkg::sel_srli] |
                    sel[alu_pkg::sel_sra] | sel[alu_pkg::sel_srai];
  assign shamt    = {shamt_hi & b[5], b[4:0]};

  // word right shifts work on a refilled upper half
  assign srl_src = (sel[alu_pkg::sel_srliw] | sel[alu_pkg::sel_srlw]) ?
                   {32'd0, a[31:0]} : a;
  assign sra_src = (sel[alu_pkg::sel_sraiw] | sel[alu_pkg::sel_sraw]) ?
                   alu_pkg::sext_word(a[31:0]) : a;

  assign sll_res = a << shamt;
  assign srl_res = srl_src >> shamt;
  assign sra_res = $signed(sra_src) >>> shamt;

  always_comb begin
    case (1'b1)
      sel[alu_pkg::sel_add],
      sel[alu_pkg::sel_sub]:    simple_out = sum;
      sel[alu_pkg::sel_addw],
      sel[alu_pkg::sel_subw]:   simple_out = sum_w;
      sel[alu_pkg::sel_slt]:    simple_out = slt_res;
      sel[alu_pkg::sel_sltu]:   simple_out = sltu_res;
      sel[alu_pkg::sel_and]:    simple_out = a & b;
      sel[alu_pkg::sel_or]:     simple_out = a | b;
      sel[alu_pkg::sel_xor]:    simple_out = a ^ b;
      sel[alu_pkg::sel_sll],
      sel[alu_pkg::sel_slli]:   simple_out = sll_res;
      sel[alu_pkg::sel_slliw],
      sel[alu_pkg::sel_sllw]:   simple_out = alu_pkg::sext_word(sll_res[31:0]);
      sel[alu_pkg::sel_srl],
      sel[alu_pkg::sel_srli]:   simple_out = srl_res;
      sel[alu_pkg::sel_srliw],
      sel[alu_pkg::sel_srlw]:   simple_out = alu_pkg::sext_word(srl_res[31:0]);
      sel[alu_pkg::sel_sra],
      sel[alu_pkg::sel_srai]:   simple_out = sra_res;
      sel[alu_pkg::sel_sraiw],
      sel[alu_pkg::sel_sraw]:   simple_out = alu_pkg::sext_word(sra_res[31:0]);
      // mul/div or idle
      default:                  simple_out = '0;
    endcase
  end

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

  // data width of the core
  localparam int xlen = 64;

  typedef logic [xlen-1:0]   word_t;
  typedef logic [xlen/2-1:0] half_t;
  typedef logic [5:0]        shamt_t;
  typedef logic [33:0]       alu_sel_t;

  // one-hot select bit positions
  localparam int sel_add    = 0;
  localparam int sel_addw   = 1;
  localparam int sel_sub    = 2;
  localparam int sel_subw   = 3;
  localparam int sel_slt    = 4;
  localparam int sel_sltu   = 5;
  localparam int sel_and    = 6;
  localparam int sel_or     = 7;
  localparam int sel_xor    = 8;
  localparam int sel_sll    = 9;
  localparam int sel_slli   = 10;
  localparam int sel_slliw  = 11;
  localparam int sel_sllw   = 12;
  localparam int sel_srl    = 13;
  localparam int sel_srli   = 14;
  localparam int sel_srliw  = 15;
  localparam int sel_srlw   = 16;
  localparam int sel_sra    = 17;
  localparam int sel_srai   = 18;
  localparam int sel_sraiw  = 19;
  localparam int sel_sraw   = 20;
  localparam int sel_rem    = 21;
  localparam int sel_remu   = 22;
  localparam int sel_remuw  = 23;
  localparam int sel_remw   = 24;
  localparam int sel_div    = 25;
  localparam int sel_divu   = 26;
  localparam int sel_divuw  = 27;
  localparam int sel_divw   = 28;
  localparam int sel_mul    = 29;
  localparam int sel_mulh   = 30;
  localparam int sel_mulhsu = 31;
  localparam int sel_mulhu  = 32;
  localparam int sel_mulw   = 33;

  // op groups: single cycle, divider, multiplier
  localparam alu_sel_t simple_mask = 34'h0_001f_ffff;
  localparam alu_sel_t div_mask    = 34'h0_1fe0_0000;
  localparam alu_sel_t mul_mask    = 34'h3_e000_0000;

  localparam int mul_cycles = 64;
  localparam int div_cycles = 64;

  typedef enum logic [1:0] {st_idle, st_busy, st_done} unit_state_e;

  typedef struct packed {
    logic     start;
    alu_sel_t sel;
    word_t    a;
    word_t    b;
  } unit_req_t;

  // sign extend a word result to xlen
  function automatic word_t sext_word(input half_t v);
    return {{(xlen/2){v[xlen/2-1]}}, v};
  endfunction

endpackage
